/* vlog.f */
seq_pkg.sv
step_if.sv
opcode_predecoder.sv
state_encoder.sv
step_controller.sv
apb_seq_regs.sv
trace_fifo.sv
seq_top.sv
tb_clkgen.sv
tb_seq.sv

/* tb_seq.sv */
// ----------------------------------------
// Directed testbench of the step sequencer,
// APB tasks and one compare task.
// ----------------------------------------
`default_nettype none

module tb_seq;
        import seq_pkg::*;

        logic           clk;
        logic           rst_n;
        logic           psel;
        logic           penable;
        logic           pwrite;
        logic [31:0]    paddr;
        logic [31:0]    pwdata;
        logic [31:0]    prdata;
        logic           pready;
        logic           pslverr;
        int             errors;
        int             timeouts;

        tb_clkgen u_clk (.clk(clk), .rst_n(rst_n));

        seq_top #(.TRACE_DEPTH(8)) u_dut (
                .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
                .prdata, .pready, .pslverr
        );

        task automatic check(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
                if (expected !== actual) begin
                        $display("** Error: %s expected %h actual %h", name, expected, actual);
                        errors++;
                end
        endtask

        // Setup cycle, access cycle, response sampled mid access.
        task automatic apb_xfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
                @(posedge clk);
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= wr;
                paddr   <= addr;
                pwdata  <= wdata;
                @(posedge clk);
                penable <= 1'b1;
                @(negedge clk);
                check("pready", 32'd1, {31'd0, pready});
                rdata = prdata;
                err   = pslverr;
                @(posedge clk);
                psel    <= 1'b0;
                penable <= 1'b0;
                pwrite  <= 1'b0;
        endtask

        task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                                 output logic err);
                logic [31:0] unused;
                apb_xfer(1'b1, addr, data, unused, err);
        endtask

        task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                                output logic err);
                apb_xfer(1'b0, addr, 32'd0, data, err);
        endtask

        task automatic wait_idle(input string name);
                logic [31:0]    st;
                logic           err;
                int             n;
                st = 32'h1;
                n  = 0;
                while (st[0] && n < 40) begin
                        apb_read(ADDR_STATUS, st, err);
                        n++;
                end
                if (st[0]) begin
                        $display("Timeout in %s: busy still set after %0d status reads", name, n);
                        timeouts++;
                end
        endtask

        task automatic wait_level(input string name, input logic [7:0] lvl);
                logic [31:0]    st;
                logic           err;
                int             n;
                st = 32'd0;
                n  = 0;
                while (st[15:8] != lvl && n < 40) begin
                        apb_read(ADDR_STATUS, st, err);
                        n++;
                end
                if (st[15:8] != lvl) begin
                        $display("Timeout in %s: FIFO level never reached %0d", name, lvl);
                        timeouts++;
                end
        endtask

        task automatic issue(input string name, input logic [31:0] word);
                logic err;
                apb_write(ADDR_OPCODE, word, err);
                check({name, " write pslverr"}, 32'd0, {31'd0, err});
                wait_idle(name);
        endtask

        // Codes of one instruction are class, then step 0 upward.
        task automatic expect_codes(input string name, input logic [3:0] cls, input int n);
                logic [31:0]    data;
                logic           err;
                for (int i = 0; i < n; i++) begin
                        apb_read(ADDR_TRACE, data, err);
                        check($sformatf("%s code %0d", name, i), {24'd0, cls, 4'(i)}, data);
                        check($sformatf("%s pop %0d pslverr", name, i), 32'd0, {31'd0, err});
                end
        endtask

        task automatic run_inst(input string name, input logic [31:0] word,
                                input logic [3:0] cls, input int n);
                logic [31:0]    st;
                logic           err;
                issue(name, word);
                apb_read(ADDR_STATUS, st, err);
                check({name, " level"}, 32'(n), {24'd0, st[15:8]});
                expect_codes(name, cls, n);
                apb_read(ADDR_STATUS, st, err);
                check({name, " drained"}, 32'd0, {24'd0, st[15:8]});
        endtask

        // Z is flags bit 1, C is bit 0.
        function automatic int cond_taken(input int cc, input logic [1:0] fl);
                case (cc)
                        0: return !fl[1];
                        1: return fl[1];
                        2: return !fl[0];
                        default: return fl[0];
                endcase
        endfunction

        task automatic test_ld();
                run_inst("ld_r_n", 32'h03E, 4'h1, 2);
                run_inst("ld_r_ix", 32'h17E, 4'h2, 4);
                run_inst("ld_r_iy", 32'h246, 4'h3, 4);
        endtask

        task automatic test_alu();
                logic [7:0] ops [4];
                ops = '{8'hE6, 8'hEE, 8'hF6, 8'hFE};
                for (int k = 0; k < 4; k++) begin
                        run_inst($sformatf("alu_n %h", ops[k]), {24'd0, ops[k]}, 4'h4, 2);
                        // Memory form is the immediate form with bit 6 cleared.
                        run_inst($sformatf("alu_ix %0d", k), {24'h1, 8'hA6 | 8'(k << 3)}, 4'h5, 4);
                        run_inst($sformatf("alu_iy %0d", k), {24'h2, 8'hA6 | 8'(k << 3)}, 4'h6, 4);
                end
        endtask

        task automatic test_branch();
                logic [1:0]     fl;
                logic           err;
                int             cc;
                int             tk;
                for (int k = 0; k < 8; k++) begin
                        cc = k % 4;
                        fl = 2'($urandom);
                        apb_write(ADDR_FLAGS, {30'd0, fl}, err);
                        check("flags write pslverr", 32'd0, {31'd0, err});
                        tk = cond_taken(cc, fl);
                        run_inst($sformatf("jp_cc %0d flags %b", cc, fl),
                                 32'hC2 | 32'(cc << 3), 4'h8, tk ? 3 : 2);
                        run_inst($sformatf("jr_cc %0d flags %b", cc, fl),
                                 32'h20 | 32'(cc << 3), 4'h9, tk ? 2 : 1);
                        run_inst($sformatf("call_cc %0d flags %b", cc, fl),
                                 32'hC4 | 32'(cc << 3), 4'hB, tk ? 5 : 3);
                end
                run_inst("jp_nn", 32'h0C3, 4'h7, 3);
                run_inst("call_nn", 32'h0CD, 4'hA, 5);
        endtask

        task automatic test_illegal();
                logic [31:0]    st;
                logic           err;
                run_inst("illegal", 32'h000, 4'hF, 1);
                apb_read(ADDR_STATUS, st, err);
                check("illegal sticky set", 32'd1, {31'd0, st[1]});
                run_inst("after illegal", 32'h03E, 4'h1, 2);
                apb_read(ADDR_STATUS, st, err);
                check("illegal sticky cleared", 32'd0, {31'd0, st[1]});
        endtask

        task automatic test_backpressure();
                logic [31:0]    st;
                logic           err;
                apb_write(ADDR_OPCODE, 32'h0CD, err);
                check("bp first call pslverr", 32'd0, {31'd0, err});
                apb_write(ADDR_OPCODE, 32'h000, err);   // Still busy.
                check("bp write while busy pslverr", 32'd1, {31'd0, err});
                apb_read(ADDR_OPCODE, st, err);
                check("bp rejected write ignored", 32'h0CD, st);
                wait_idle("bp first call");
                apb_write(ADDR_OPCODE, 32'h0CD, err);
                check("bp second call pslverr", 32'd0, {31'd0, err});
                wait_level("bp fill", 8'd8);
                apb_read(ADDR_STATUS, st, err);
                check("bp held busy", 32'd1, {31'd0, st[0]});
                expect_codes("bp drain first", 4'hA, 5);
                expect_codes("bp drain second", 4'hA, 5);
                wait_idle("bp second call");
                apb_read(ADDR_STATUS, st, err);
                check("bp final status", 32'd0, st);
        endtask

        task automatic test_empty_read();
                logic [31:0]    data;
                logic           err;
                apb_read(ADDR_TRACE, data, err);
                check("empty read pslverr", 32'd1, {31'd0, err});
                check("empty read data", 32'd0, data);
        endtask

        initial begin
                logic [31:0]    st;
                logic           err;
                int             n;
                errors    = 0;
                timeouts  = 0;
                void'($urandom(32'h2a7));
                psel    <= 1'b0;
                penable <= 1'b0;
                pwrite  <= 1'b0;
                paddr   <= 32'd0;
                pwdata  <= 32'd0;
                n = 0;
                while (rst_n !== 1'b1 && n < 20) begin
                        @(posedge clk);
                        n++;
                end
                if (rst_n !== 1'b1) begin
                        $display("Timeout: reset was never released");
                        timeouts++;
                end
                apb_read(ADDR_STATUS, st, err);
                check("status after reset", 32'd0, st);
                test_ld();
                test_alu();
                test_branch();
                test_illegal();
                test_backpressure();
                test_empty_read();
                $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// ----------------------------------------
// Testbench clock and reset generator.
// ----------------------------------------
`default_nettype none

module tb_clkgen #(
        parameter int PERIOD     = 20,
        parameter int RST_CYCLES = 4
) (
        output logic clk,
        output logic rst_n
);
        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        initial begin
                rst_n = 1'b0;
                repeat (RST_CYCLES) @(posedge clk);
                rst_n <= 1'b1;          // Released on a rising edge.
        end

endmodule

`default_nettype wire

/* seq_top.sv */
// ----------------------------------------
// Step sequencer top: APB regs, controller,
// encoder and trace FIFO.
// ----------------------------------------
`default_nettype none

module seq_top #(
        parameter int TRACE_DEPTH = seq_pkg::TRACE_DEPTH_DEF
) (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            psel,
        input  logic            penable,
        input  logic            pwrite,
        input  logic [31:0]     paddr,
        input  logic [31:0]     pwdata,
        output logic [31:0]     prdata,
        output logic            pready,
        output logic            pslverr
);
        import seq_pkg::*;

        localparam int LW = $clog2(TRACE_DEPTH + 1);

        logic           start, busy, illegal;
        logic           push, pop, full, empty;
        prefix_e        prefix;
        logic [7:0]     opcode;
        logic [1:0]     flags;
        step_code_t     push_data, pop_data;
        logic [LW-1:0]  level;

        step_if u_sif (.clk(clk), .rst_n(rst_n));

        apb_seq_regs #(.TRACE_DEPTH(TRACE_DEPTH)) u_regs (
                .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
                .prdata, .pready, .pslverr, .start, .prefix, .opcode, .flags,
                .busy, .illegal, .pop, .pop_data, .empty, .level
        );

        step_controller u_ctrl (
                .clk, .rst_n, .start, .prefix, .opcode, .flags, .busy, .illegal,
                .push, .push_data, .full, .sif(u_sif.ctrl)
        );

        state_encoder u_enc (.sif(u_sif.enc));

        trace_fifo #(.DEPTH(TRACE_DEPTH)) u_fifo (
                .clk, .rst_n, .push, .push_data, .pop, .pop_data, .full, .empty, .level
        );

endmodule

`default_nettype wire

/* trace_fifo.sv */
// ----------------------------------------
// Trace FIFO of step codes, show-ahead read.
// ----------------------------------------
`default_nettype none

module trace_fifo #(
        parameter int DEPTH = seq_pkg::TRACE_DEPTH_DEF
) (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            push,
        input  seq_pkg::step_code_t             push_data,
        input  logic                            pop,
        output seq_pkg::step_code_t             pop_data,
        output logic                            full,
        output logic                            empty,
        output logic [$clog2(DEPTH+1)-1:0]      level
);
        import seq_pkg::*;

        localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int LW = $clog2(DEPTH + 1);

        step_code_t     mem [DEPTH];
        logic [AW-1:0]  wr_ptr;
        logic [AW-1:0]  rd_ptr;
        logic           do_push;
        logic           do_pop;

        assign full     = (level == LW'(DEPTH));
        assign empty    = (level == '0);
        assign do_push  = push && !full;
        assign do_pop   = pop && !empty;
        assign pop_data = mem[rd_ptr];

        always_ff @(posedge clk) begin
                if (do_push) mem[wr_ptr] <= push_data;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        level  <= '0;
                end else begin
                        if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        if (do_pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        level <= level + LW'(do_push) - LW'(do_pop);
                end
        end

        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
        a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

`default_nettype wire

/* apb_seq_regs.sv */
// ----------------------------------------
// APB slave: opcode, flags, status and
// trace registers with error responses.
// ----------------------------------------
`default_nettype none

module apb_seq_regs #(
        parameter int TRACE_DEPTH = seq_pkg::TRACE_DEPTH_DEF
) (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            psel,
        input  logic                            penable,
        input  logic                            pwrite,
        input  logic [31:0]                     paddr,
        input  logic [31:0]                     pwdata,
        output logic [31:0]                     prdata,
        output logic                            pready,
        output logic                            pslverr,
        output logic                            start,
        output seq_pkg::prefix_e                prefix,
        output logic [7:0]                      opcode,
        output logic [1:0]                      flags,
        input  logic                            busy,
        input  logic                            illegal,
        output logic                            pop,
        input  seq_pkg::step_code_t             pop_data,
        input  logic                            empty,
        input  logic [$clog2(TRACE_DEPTH+1)-1:0] level
);
        import seq_pkg::*;

        logic access;
        logic wr_acc;
        logic rd_acc;
        logic ill_sticky;

        assign access = psel && penable;
        assign wr_acc = access && pwrite;
        assign rd_acc = access && !pwrite;

        assign pready  = 1'b1;          // Zero wait states.
        assign start   = wr_acc && (paddr == ADDR_OPCODE) && !busy;
        assign pop     = rd_acc && (paddr == ADDR_TRACE) && !empty;
        assign pslverr = (wr_acc && (paddr == ADDR_OPCODE) && busy) ||
                         (rd_acc && (paddr == ADDR_TRACE) && empty);

        always_comb begin
                prdata = '0;
                if (rd_acc) begin
                        case (paddr)
                                ADDR_OPCODE: prdata = {22'd0, prefix, opcode};
                                ADDR_FLAGS:  prdata = {30'd0, flags};
                                ADDR_STATUS: prdata = {16'd0, 8'(level), 6'd0, ill_sticky, busy};
                                ADDR_TRACE:  prdata = empty ? '0 : {24'd0, pop_data};
                                default:     prdata = '0;
                        endcase
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        prefix     <= PFX_NONE;
                        opcode     <= '0;
                        flags      <= '0;
                        ill_sticky <= 1'b0;
                end else begin
                        if (start) begin
                                prefix <= prefix_e'(pwdata[9:8]);
                                opcode <= pwdata[7:0];
                        end
                        if (wr_acc && paddr == ADDR_FLAGS) flags <= pwdata[1:0];
                        // Illegal pulse comes one cycle after the clearing write.
                        if (illegal) ill_sticky <= 1'b1;
                        else if (start) ill_sticky <= 1'b0;
                end
        end

endmodule

`default_nettype wire

/* step_controller.sv */
// ----------------------------------------
// Step controller: sequencing FSM, step
// counter, condition check, flip-flop I.
// ----------------------------------------
`default_nettype none

module step_controller (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    start,
        input  seq_pkg::prefix_e        prefix,
        input  logic [7:0]              opcode,
        input  logic [1:0]              flags,          // {Z, C}
        output logic                    busy,
        output logic                    illegal,
        output logic                    push,
        output seq_pkg::step_code_t     push_data,
        input  logic                    full,
        step_if.ctrl                    sif
);
        import seq_pkg::*;

        typedef enum logic [1:0] {S_IDLE, S_DECODE, S_RUN} state_e;

        state_e         state;
        inst_class_e    dec_class;
        inst_class_e    cls;
        cond_e          cc;
        logic           taken;
        logic [3:0]     n_steps;
        logic [3:0]     step_idx;
        logic [3:0]     last_idx;
        step_code_t     ff_i;

        opcode_predecoder u_predec (
                .prefix     (prefix),
                .opcode     (opcode),
                .inst_class (dec_class),
                .cc         (cc)
        );

        always_comb begin
                taken = 1'b0;
                case (cc)
                        CC_NZ: taken = !flags[1];
                        CC_Z:  taken = flags[1];
                        CC_NC: taken = !flags[0];
                        CC_C:  taken = flags[0];
                        default: taken = 1'b0;
                endcase
        end

        always_comb begin
                case (dec_class)
                        LD_R_N, ALU_N:                          n_steps = 4'd2;
                        LD_R_IX, LD_R_IY, ALU_IX, ALU_IY:       n_steps = 4'd4;
                        JP_NN:                                  n_steps = 4'd3;
                        JP_CC:          n_steps = taken ? 4'd3 : 4'd2;
                        JR_CC:          n_steps = taken ? 4'd2 : 4'd1;
                        CALL_NN:                                n_steps = 4'd5;
                        CALL_CC:        n_steps = taken ? 4'd5 : 4'd3;
                        default:                                n_steps = 4'd1;
                endcase
        end

        assign busy    = (state != S_IDLE);
        assign illegal = (state == S_DECODE) && (dec_class == ILLEGAL);

        assign sif.valid   = (state == S_RUN);
        assign sif.set_req = sif.valid ? (N_CLASS'(1) << cls) : '0;
        assign sif.step    = step_idx;

        assign push      = sif.valid && !full;  // Step holds while the FIFO is full.
        assign push_data = sif.code;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state    <= S_IDLE;
                        cls      <= ILLEGAL;
                        step_idx <= '0;
                        last_idx <= '0;
                        ff_i     <= '0;
                end else begin
                        case (state)
                                S_IDLE: if (start) state <= S_DECODE;
                                S_DECODE: begin
                                        cls      <= dec_class;  // Flags sampled here.
                                        last_idx <= n_steps - 4'd1;
                                        step_idx <= '0;
                                        state    <= S_RUN;
                                end
                                S_RUN: if (push) begin
                                        ff_i     <= sif.code;
                                        step_idx <= step_idx + 4'd1;
                                        if (step_idx == last_idx) state <= S_IDLE;
                                end
                                default: state <= S_IDLE;
                        endcase
                end
        end

        a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                sif.valid |-> $onehot(sif.set_req));

        a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
                push |-> !full);

        // Codes of one instruction follow flip-flop I by one step.
        a_step_order: assert property (@(posedge clk) disable iff (!rst_n)
                push && step_idx != 4'd0 |-> push_data == ff_i + 8'd1);

endmodule

`default_nettype wire

/* state_encoder.sv */
// ----------------------------------------
// Flip-flop I encoder: OR of set requests
// per code bit plus the step index.
// ----------------------------------------
`default_nettype none

module state_encoder (
        step_if.enc sif
);
        import seq_pkg::*;

        logic [3:0] class_bits;

        // Set requests of all classes whose code has bit b set.
        function automatic logic [N_CLASS-1:0] members(input int b);
                logic [N_CLASS-1:0] m;
                for (int i = 0; i < N_CLASS; i++) begin
                        m[i] = i[b];
                end
                return m;
        endfunction

        for (genvar b = 0; b < 4; b++) begin : g_bit
                assign class_bits[b] = |(sif.set_req & members(b));
        end

        assign sif.code = {class_bits, sif.step};

        // A live step always names a real class.
        a_code_nonzero: assert property (@(posedge sif.clk) disable iff (!sif.rst_n)
                sif.valid |-> sif.code != '0);

endmodule

`default_nettype wire

/* opcode_predecoder.sv */
// ----------------------------------------
// Opcode predecoder: prefix and opcode to
// instruction class and condition field.
// ----------------------------------------
`default_nettype none

module opcode_predecoder (
        input  seq_pkg::prefix_e        prefix,
        input  logic [7:0]              opcode,
        output seq_pkg::inst_class_e    inst_class,
        output seq_pkg::cond_e          cc
);
        import seq_pkg::*;

        logic [2:0] r_field;
        logic       low_110;
        logic       indexed;

        assign r_field = opcode[5:3];
        assign low_110 = (opcode[2:0] == 3'b110);
        assign indexed = (prefix == PFX_IX) || (prefix == PFX_IY);

        always_comb begin
                inst_class = ILLEGAL;
                if (prefix == PFX_NONE) begin
                        if (opcode[7:6] == 2'b00 && low_110 && r_field != 3'b110) begin
                                inst_class = LD_R_N;            // 00rrr110
                        end else if (opcode[7:6] == 2'b11 && low_110 && r_field[2]) begin
                                inst_class = ALU_N;             // E6 EE F6 FE
                        end else if (opcode == 8'hC3) begin
                                inst_class = JP_NN;
                        end else if (opcode[7:5] == 3'b110 && opcode[2:0] == 3'b010) begin
                                inst_class = JP_CC;
                        end else if (opcode[7:5] == 3'b001 && opcode[2:0] == 3'b000) begin
                                inst_class = JR_CC;
                        end else if (opcode == 8'hCD) begin
                                inst_class = CALL_NN;
                        end else if (opcode[7:5] == 3'b110 && opcode[2:0] == 3'b100) begin
                                inst_class = CALL_CC;
                        end
                end else if (indexed) begin
                        // Only the (IX+d) and (IY+d) memory forms are known here.
                        if (opcode[7:6] == 2'b01 && low_110 && r_field != 3'b110) begin
                                inst_class = (prefix == PFX_IX) ? LD_R_IX : LD_R_IY;
                        end else if (opcode[7:6] == 2'b10 && low_110 && r_field[2]) begin
                                inst_class = (prefix == PFX_IX) ? ALU_IX : ALU_IY;
                        end
                end
        end

        assign cc = cond_e'(opcode[4:3]);       // Only meaningful for the cc classes.

endmodule

`default_nettype wire

/* step_if.sv */
// ----------------------------------------
// Set requests and step code between the
// controller and the state encoder.
// ----------------------------------------
`default_nettype none

interface step_if (
        input logic clk,
        input logic rst_n
);
        import seq_pkg::*;

        logic                   valid;
        logic [N_CLASS-1:0]     set_req;        // One-hot by class code.
        logic [3:0]             step;
        step_code_t             code;

        modport ctrl (output valid, output set_req, output step, input code);
        modport enc (input clk, input rst_n, input valid, input set_req, input step,
                     output code);

endinterface

`default_nettype wire

/* seq_pkg.sv */
// ----------------------------------------
// Shared types of the step sequencer: class
// codes, step code, APB map, default sizes.
// ----------------------------------------
`default_nettype none

package seq_pkg;

        // Upper nibble class, lower nibble step index.
        typedef logic [7:0] step_code_t;

        typedef enum logic [3:0] {
                LD_R_N  = 4'd1,
                LD_R_IX = 4'd2,
                LD_R_IY = 4'd3,
                ALU_N   = 4'd4,
                ALU_IX  = 4'd5,
                ALU_IY  = 4'd6,
                JP_NN   = 4'd7,
                JP_CC   = 4'd8,
                JR_CC   = 4'd9,
                CALL_NN = 4'd10,
                CALL_CC = 4'd11,
                ILLEGAL = 4'd15
        } inst_class_e;

        localparam int N_CLASS = 16;    // Width of the one-hot set requests.

        typedef enum logic [1:0] {
                PFX_NONE = 2'd0,
                PFX_IX   = 2'd1,        // DD prefix.
                PFX_IY   = 2'd2         // FD prefix.
        } prefix_e;

        // Same order as the cc field of the opcode.
        typedef enum logic [1:0] {
                CC_NZ = 2'd0,
                CC_Z  = 2'd1,
                CC_NC = 2'd2,
                CC_C  = 2'd3
        } cond_e;

        localparam logic [31:0] ADDR_OPCODE = 32'h0;
        localparam logic [31:0] ADDR_FLAGS  = 32'h4;
        localparam logic [31:0] ADDR_STATUS = 32'h8;
        localparam logic [31:0] ADDR_TRACE  = 32'hC;

        localparam int TRACE_DEPTH_DEF = 8;

endpackage

`default_nettype wire
